//--- Makefile
SRCS := $(shell cat list.f)

run: obj_dir/Vtb_traffic_light
	@out="$$(./obj_dir/Vtb_traffic_light)"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

obj_dir/Vtb_traffic_light: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_traffic_light -f list.f

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- auto_sequencer.sv
`timescale 1ns/1ps

module auto_sequencer #(
    parameter int unsigned TICKS_PER_SEC = tl_timing_pkg::DEFAULT_TICKS_PER_SEC
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                manual,
    input  logic                manual_rise,
    input  tl_timing_pkg::sec_t n_duration,
    input  tl_timing_pkg::sec_t e_duration,
    input  tl_timing_pkg::sec_t s_duration,
    input  tl_timing_pkg::sec_t w_duration,
    input  tl_timing_pkg::sec_t yellow_duration,
    input  tl_timing_pkg::sec_t red_holding,
    tl_phase_if.seq             ph
);
    import tl_types_pkg::*;
    import tl_timing_pkg::*;

    localparam tick_t TICK_LAST = tick_t'(TICKS_PER_SEC - 1);

    phase_t phase_q;
    phase_t phase_nxt;
    tick_t  tick_cnt;       // Cycles into the current second
    sec_t   sec_cnt;        // Whole seconds elapsed in phase
    sec_t   dur;            // Current phase length, at least 1
    logic   pending_q;
    logic   hold;           // Pure manual, park at N_GREEN
    logic   sec_end;
    logic   phase_end;
    logic   enter_all_red;

    //==========================================================================
    // Phase length and successor
    //==========================================================================
    always_comb begin
        case (phase_q)
            N_GREEN: dur = min_one_sec(n_duration);
            E_GREEN: dur = min_one_sec(e_duration);
            S_GREEN: dur = min_one_sec(s_duration);
            W_GREEN: dur = min_one_sec(w_duration);
            N_YELLOW, E_YELLOW, S_YELLOW, W_YELLOW:
                dur = min_one_sec(yellow_duration);
            default: dur = min_one_sec(red_holding);   // All-red phases
        endcase
    end

    // Cycle order, wraps back to North
    assign phase_nxt = (phase_q == W_ALL_RED) ? N_GREEN : phase_t'(phase_q + 1'b1);

    assign hold      = manual && !pending_q && !manual_rise;
    assign sec_end   = (tick_cnt == TICK_LAST);
    assign phase_end = sec_end && (sec_cnt >= dur - 1'b1);

    assign enter_all_red = !hold && phase_end &&
                           (phase_nxt inside {N_ALL_RED, E_ALL_RED, S_ALL_RED, W_ALL_RED});

    //==========================================================================
    // Phase, tick and seconds counters
    //==========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q  <= N_GREEN;
            tick_cnt <= '0;
            sec_cnt  <= '0;
        end else if (hold) begin
            phase_q  <= N_GREEN;                // Restart point for return to auto
            tick_cnt <= '0;
            sec_cnt  <= '0;
        end else if (sec_end) begin
            tick_cnt <= '0;
            if (phase_end) begin
                phase_q <= phase_nxt;
                sec_cnt <= '0;                  // Reload for the new phase
            end else begin
                sec_cnt <= sec_cnt + 1'b1;
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Handover flag, cleared at the first all-red or when back in auto
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (!manual || enter_all_red) begin
            pending_q <= 1'b0;
        end else if (manual_rise) begin
            pending_q <= 1'b1;
        end
    end

    assign ph.phase     = phase_q;
    assign ph.pending   = pending_q;
    assign ph.remaining = dur - sec_cnt;        // Counts down to 1

    // Handover only starts from a manual request
    a_pending_needs_manual: assert property (
        @(posedge clk) disable iff (rst) $rose(pending_q) |-> $past(manual)
    ) else $error("pending rose while in auto mode");

    a_remaining_nonzero: assert property (
        @(posedge clk) disable iff (rst) ph.remaining != '0
    ) else $error("countdown reached zero");

endmodule

//--- lamp_driver.sv
`timescale 1ns/1ps

module lamp_driver (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   manual,
    input  tl_types_pkg::lamp_t    dir_sw,
    tl_phase_if.drv                ph,
    output tl_types_pkg::lamp_t    red_lamps,
    output tl_types_pkg::lamp_t    yellow_lamps,
    output tl_types_pkg::lamp_t    green_lamps,
    output tl_types_pkg::dir_t     active_direction,
    output tl_timing_pkg::sec_t    countdown_sec,
    output logic                   show_countdown,
    output tl_timing_pkg::count_t  yellow_light_count
);
    import tl_types_pkg::*;

    dir_t  ph_dir;          // Direction of the auto phase
    dir_t  sw_dir;          // First set switch, North if none
    lamp_t ph_onehot;
    lamp_t sw_first;
    logic  auto_view;       // Auto lamps shown, incl. handover
    logic  yellow_any;
    logic  yellow_any_q;

    assign auto_view = !manual || ph.pending;
    assign sw_first  = first_set(dir_sw);       // Priority N, E, S, W

    //==========================================================================
    // Direction decode
    //==========================================================================
    always_comb begin
        case (ph.phase)
            N_GREEN, N_YELLOW, N_ALL_RED: ph_dir = 2'd0;
            E_GREEN, E_YELLOW, E_ALL_RED: ph_dir = 2'd1;
            S_GREEN, S_YELLOW, S_ALL_RED: ph_dir = 2'd2;
            default:                      ph_dir = 2'd3;
        endcase
    end

    assign ph_onehot = lamp_t'(1) << ph_dir;

    always_comb begin
        case (sw_first)
            4'b0010: sw_dir = 2'd1;
            4'b0100: sw_dir = 2'd2;
            4'b1000: sw_dir = 2'd3;
            default: sw_dir = 2'd0;             // North, or nothing set
        endcase
    end

    //==========================================================================
    // Lamp selection
    //==========================================================================
    always_comb begin
        yellow_lamps = '0;                      // Default all red
        green_lamps  = '0;
        if (auto_view) begin
            case (ph.phase)
                N_GREEN, E_GREEN, S_GREEN, W_GREEN:     green_lamps  = ph_onehot;
                N_YELLOW, E_YELLOW, S_YELLOW, W_YELLOW: yellow_lamps = ph_onehot;
                default: ;
            endcase
        end else begin
            case (ph.man_state)
                IDLE:    green_lamps  = sw_first;
                YELLOW:  yellow_lamps = ph.man_yellow;
                default: ;                      // RED hold
            endcase
        end
    end

    assign red_lamps        = ~(yellow_lamps | green_lamps);
    assign active_direction = auto_view ? ph_dir : sw_dir;
    assign countdown_sec    = ph.remaining;
    assign show_countdown   = auto_view;        // Hidden in pure manual

    // Yellow onset counter, auto and manual alike
    assign yellow_any = |yellow_lamps;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            yellow_any_q       <= 1'b0;
            yellow_light_count <= '0;
        end else begin
            yellow_any_q <= yellow_any;
            if (yellow_any && !yellow_any_q) begin
                yellow_light_count <= yellow_light_count + 1'b1;
            end
        end
    end

    a_single_green: assert property (
        @(posedge clk) disable iff (rst) $onehot0(green_lamps)
    ) else $error("conflicting greens %b", green_lamps);

endmodule

//--- list.f
tl_types_pkg.sv
tl_timing_pkg.sv
tl_phase_if.sv
switch_conditioner.sv
auto_sequencer.sv
manual_controller.sv
lamp_driver.sv
traffic_light_top.sv
tb_traffic_light.sv

//--- manual_controller.sv
`timescale 1ns/1ps

module manual_controller #(
    parameter int unsigned TICKS_PER_SEC = tl_timing_pkg::DEFAULT_TICKS_PER_SEC
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                manual,
    input  tl_types_pkg::lamp_t dir_off,
    input  tl_timing_pkg::sec_t yellow_duration,
    input  tl_timing_pkg::sec_t red_holding,
    tl_phase_if.man             ph
);
    import tl_types_pkg::*;
    import tl_timing_pkg::*;

    localparam tick_t TICK_LAST = tick_t'(TICKS_PER_SEC - 1);

    man_state_t state_q;
    lamp_t      man_yellow_q;
    tick_t      tick_cnt;
    sec_t       sec_cnt;
    sec_t       step_secs;      // Length of current YELLOW or RED step
    logic       active;
    logic       sec_end;
    logic       step_end;

    assign active    = manual && !ph.pending;   // Pure manual only
    assign step_secs = (state_q == YELLOW) ? min_one_sec(yellow_duration)
                                           : min_one_sec(red_holding);
    assign sec_end   = (tick_cnt == TICK_LAST);
    assign step_end  = sec_end && (sec_cnt >= step_secs - 1'b1);

    //==========================================================================
    // Clearance FSM  IDLE -> YELLOW -> RED -> IDLE
    //==========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            tick_cnt <= '0;
            sec_cnt  <= '0;
        end else if (!active) begin
            state_q  <= IDLE;                   // Auto or handover owns the lamps
            tick_cnt <= '0;
            sec_cnt  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    tick_cnt <= '0;
                    sec_cnt  <= '0;
                    if (|dir_off) begin
                        state_q <= YELLOW;      // Switch turned off
                    end
                end
                default: begin                  // YELLOW or RED, timed
                    if (sec_end) begin
                        tick_cnt <= '0;
                        if (step_end) begin
                            sec_cnt <= '0;
                            state_q <= (state_q == YELLOW) ? RED : IDLE;
                        end else begin
                            sec_cnt <= sec_cnt + 1'b1;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Direction to clear, lowest index wins on simultaneous edges
    always_ff @(posedge clk) begin
        if (active && state_q == IDLE && |dir_off) begin
            man_yellow_q <= first_set(dir_off);
        end
    end

    assign ph.man_state  = state_q;
    assign ph.man_yellow = man_yellow_q;

    a_yellow_onehot: assert property (
        @(posedge clk) disable iff (rst) (state_q == YELLOW) |-> $onehot(man_yellow_q)
    ) else $error("manual yellow not one-hot");

endmodule

//--- switch_conditioner.sv
`timescale 1ns/1ps

module switch_conditioner (
    input  logic                clk,
    input  logic                rst,
    input  tl_types_pkg::sw_t   switches,
    output logic                manual,
    output logic                manual_rise,
    output tl_types_pkg::lamp_t dir_sw,
    output tl_types_pkg::lamp_t dir_off
);
    import tl_types_pkg::*;

    //==========================================================================
    // Two-flop synchronizer plus edge history
    //==========================================================================
    sw_t meta_q;    // First stage, may go metastable
    sw_t sync_q;    // Safe to use
    sw_t prev_q;    // sync_q one cycle ago

    // Zero reset so a switch held through reset looks like a rising edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= switches;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    //==========================================================================
    // Levels and edges
    //==========================================================================
    assign manual      = sync_q[0];                 // 1 = manual mode
    assign manual_rise = sync_q[0] & ~prev_q[0];    // Auto to manual request

    // Direction levels, W S E N
    assign dir_sw = sync_q[4:1];

    // Falling edges, high in the first cycle of the new level
    assign dir_off = prev_q[4:1] & ~sync_q[4:1];

endmodule

//--- tb_traffic_light.sv
`timescale 1ns/1ps

module tb_traffic_light;

    //==========================================================================
    // Test constants
    //==========================================================================
    localparam int TB_TICKS = 4;            // Clock cycles per second
    localparam int N_SECS   = 2;
    localparam int E_SECS   = 3;
    localparam int S_SECS   = 1;
    localparam int W_SECS   = 2;
    localparam int YEL_SECS = 1;
    localparam int RED_SECS = 1;

    // One pass through all twelve auto phases, in cycles
    localparam int CYCLE_LEN = (N_SECS + E_SECS + S_SECS + W_SECS
                                + 4 * YEL_SECS + 4 * RED_SECS) * TB_TICKS;
    localparam int WAIT_LIMIT   = CYCLE_LEN;                // Longest single wait
    localparam int MANUAL_WAITS = 8 * WAIT_LIMIT;
    localparam int WATCHDOG_NS  = 2 * (4 * CYCLE_LEN + MANUAL_WAITS) * 20;

    // Conditions for wait_until
    localparam int EV_GREEN_ON   = 0;
    localparam int EV_YELLOW_ON  = 1;
    localparam int EV_YELLOW_OFF = 2;
    localparam int EV_SHOW_HIGH  = 3;
    localparam int EV_SHOW_LOW   = 4;
    localparam int EV_MODEL_MAN  = 5;

    logic       clk;
    logic       rst;
    logic [4:0] switches;                   // W S E N manual
    logic [3:0] red_lamps;
    logic [3:0] yellow_lamps;
    logic [3:0] green_lamps;
    logic [1:0] active_direction;
    logic [7:0] countdown_sec;
    logic       show_countdown;
    logic [7:0] yellow_light_count;

    int errors       = 0;
    int lamp_errs    = 0;
    int cd_errs      = 0;
    int cnt_errs     = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    traffic_light_top #(
        .TICKS_PER_SEC (TB_TICKS)
    ) dut_i (
        .clk                (clk),
        .rst                (rst),
        .switches           (switches),
        .n_duration         (8'(N_SECS)),
        .e_duration         (8'(E_SECS)),
        .s_duration         (8'(S_SECS)),
        .w_duration         (8'(W_SECS)),
        .yellow_duration    (8'(YEL_SECS)),
        .red_holding        (8'(RED_SECS)),
        .red_lamps          (red_lamps),
        .yellow_lamps       (yellow_lamps),
        .green_lamps        (green_lamps),
        .active_direction   (active_direction),
        .countdown_sec      (countdown_sec),
        .show_countdown     (show_countdown),
        .yellow_light_count (yellow_light_count)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                  // 20 ns period

    //==========================================================================
    // Reference functions
    //==========================================================================
    // Seconds of auto phase p, 0 = N_GREEN up to 11 = W_ALL_RED
    function automatic int phase_secs(input int p);
        int s;
        case (p % 3)
            0: begin
                case (p / 3)
                    0:       s = N_SECS;
                    1:       s = E_SECS;
                    2:       s = S_SECS;
                    default: s = W_SECS;
                endcase
            end
            1:       s = YEL_SECS;
            default: s = RED_SECS;
        endcase
        return (s == 0) ? 1 : s;            // Zero runs as one second
    endfunction

    // {red, yellow, green} for an auto phase
    function automatic logic [11:0] expect_lamps(input int p);
        logic [3:0] one;
        logic [3:0] yel;
        logic [3:0] grn;
        one = 4'b0001 << (p / 3);
        grn = (p % 3 == 0) ? one : 4'b0000;
        yel = (p % 3 == 1) ? one : 4'b0000;
        return {~(yel | grn), yel, grn};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void report_mismatch(input string sig, input logic [31:0] exp_v,
                                            input logic [31:0] got_v);
        $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, sig, exp_v, got_v);
        errors++;
    endfunction

    // Returns the number of wrong lamp vectors
    function automatic int check_lamps(input logic [3:0] r, input logic [3:0] y,
                                       input logic [3:0] g);
        int n;
        n = 0;
        if (red_lamps !== r) begin
            report_mismatch("red_lamps", r, red_lamps);
            n++;
        end
        if (yellow_lamps !== y) begin
            report_mismatch("yellow_lamps", y, yellow_lamps);
            n++;
        end
        if (green_lamps !== g) begin
            report_mismatch("green_lamps", g, green_lamps);
            n++;
        end
        return n;
    endfunction

    //==========================================================================
    // Auto model, one step per rising edge
    //==========================================================================
    logic m_sw1;                            // Synchronizer stages
    logic m_manual;
    logic m_manual_q;
    logic m_pending;
    int   m_phase;
    int   m_cyc;                            // Cycles spent in m_phase
    logic m_rise;
    logic m_hold;
    logic m_last;
    logic m_view;                           // Auto lamps expected
    int   m_remaining;

    assign m_rise      = m_manual && !m_manual_q;
    assign m_hold      = m_manual && !m_pending && !m_rise;    // Rise cycle is still auto
    assign m_last      = (m_cyc == phase_secs(m_phase) * TB_TICKS - 1);
    assign m_view      = !m_manual || m_pending;
    assign m_remaining = phase_secs(m_phase) - m_cyc / TB_TICKS;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_sw1      <= 1'b0;
            m_manual   <= 1'b0;
            m_manual_q <= 1'b0;
            m_pending  <= 1'b0;
            m_phase    <= 0;
            m_cyc      <= 0;
        end else begin
            m_sw1      <= switches[0];
            m_manual   <= m_sw1;
            m_manual_q <= m_manual;
            if (m_hold) begin
                m_phase <= 0;               // Parked at N_GREEN
                m_cyc   <= 0;
            end else if (m_last) begin
                m_phase <= (m_phase + 1) % 12;
                m_cyc   <= 0;
            end else begin
                m_cyc <= m_cyc + 1;
            end
            // Handover done once the next phase is an all-red one
            if (!m_manual || (!m_hold && m_last && (m_phase + 1) % 3 == 2)) begin
                m_pending <= 1'b0;
            end else if (m_rise) begin
                m_pending <= 1'b1;
            end
        end
    end

    //==========================================================================
    // Compare process, samples at the falling edge
    //==========================================================================
    logic [11:0] exp_l;
    logic [3:0]  exp_yel_q;
    logic [7:0]  count_q;
    logic        onset_q;                   // Yellow onset in the last cycle
    logic        cnt_en;                    // Count tracking, set by stimulus
    logic        cnt_en_q;

    always @(negedge clk) begin
        if (!rst) begin
            exp_l = expect_lamps(m_phase);
            if (show_countdown !== m_view) begin
                report_mismatch("show_countdown", m_view, show_countdown);
                lamp_errs++;
            end
            if (m_view) begin
                lamp_errs += check_lamps(exp_l[11:8], exp_l[7:4], exp_l[3:0]);
                if (active_direction !== 2'(m_phase / 3)) begin
                    report_mismatch("active_direction", m_phase / 3, active_direction);
                    lamp_errs++;
                end
            end
            if (countdown_sec !== 8'(m_remaining)) begin
                report_mismatch("countdown_sec", m_remaining, countdown_sec);
                cd_errs++;
            end
            if (cnt_en && cnt_en_q && yellow_light_count !== count_q + 8'(onset_q)) begin
                report_mismatch("yellow_light_count", count_q + 8'(onset_q),
                                yellow_light_count);
                cnt_errs++;
            end
            onset_q   = m_view && exp_l[7:4] != 4'b0000 && exp_yel_q == 4'b0000;
            exp_yel_q = m_view ? exp_l[7:4] : 4'b0000;
            count_q   = yellow_light_count;
            cnt_en_q  = cnt_en;
        end
    end

    //==========================================================================
    // Stimulus helpers
    //==========================================================================
    task automatic set_switches(input logic [4:0] v);
        @(posedge clk);
        switches <= v;
    endtask

    // Two edges of synchronizer latency, then sample
    task automatic wait_sync_latency();
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    function automatic bit event_seen(input int what);
        case (what)
            EV_GREEN_ON:   return green_lamps != 4'b0000;
            EV_YELLOW_ON:  return yellow_lamps != 4'b0000;
            EV_YELLOW_OFF: return yellow_lamps == 4'b0000;
            EV_SHOW_HIGH:  return show_countdown == 1'b1;
            EV_SHOW_LOW:   return show_countdown == 1'b0;
            default:       return m_manual == 1'b1;
        endcase
    endfunction

    // Returns at the first falling edge where the condition holds
    task automatic wait_until(input int what, input string label);
        int n;
        n = 0;
        @(negedge clk);
        while (!event_seen(what) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!event_seen(what)) begin
            $display("Error at %0t ns: %s did not happen within %0d cycles",
                     $time, label, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int n);
        tests_run++;
        if (n == 0) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, n);
        end
    endtask

    //==========================================================================
    // Stimulus
    //==========================================================================
    logic [31:0] rnd;
    logic [7:0]  base;
    int          e0;

    initial begin
        rst       = 1'b1;
        switches  = 5'b00000;
        cnt_en    = 1'b0;
        cnt_en_q  = 1'b0;
        exp_yel_q = 4'b0000;
        count_q   = 8'd0;
        onset_q   = 1'b0;
        rnd       = 32'h1d73_2ddb;
        repeat (3) @(posedge clk);
        rst    <= 1'b0;
        cnt_en <= 1'b1;

        // Two full auto cycles, checked every cycle by the compare process
        repeat (2 * CYCLE_LEN) @(posedge clk);
        @(negedge clk);
        close_test("auto_cycle", lamp_errs);
        close_test("countdown", cd_errs);
        close_test("yellow_count", cnt_errs);

        // Handover at a random point of the cycle
        e0  = errors;
        rnd = lcg_next(rnd);
        repeat (8 + rnd[23:16] % 48) @(posedge clk);
        cnt_en <= 1'b0;
        set_switches(5'b00001);
        wait_until(EV_MODEL_MAN, "manual level in the model");
        wait_until(EV_SHOW_LOW, "handover to manual");
        if (m_phase % 3 != 2) begin
            $display("Error at %0t ns: handover outside an all-red phase, model phase %0d",
                     $time, m_phase);
            errors++;
        end
        if (green_lamps !== 4'b0000) begin
            report_mismatch("green_lamps", 4'b0000, green_lamps);
        end
        close_test("handover", errors - e0);

        // Manual sequential mode
        e0  = errors;
        rnd = lcg_next(rnd);
        repeat (2 + rnd[23:16] % 6) @(posedge clk);
        set_switches(5'b01101);             // E and S
        wait_sync_latency();
        void'(check_lamps(4'b1101, 4'b0000, 4'b0010));
        if (active_direction !== 2'd1) begin
            report_mismatch("active_direction", 2'd1, active_direction);
        end
        set_switches(5'b01001);             // E off
        wait_until(EV_YELLOW_ON, "E yellow");
        void'(check_lamps(4'b1101, 4'b0010, 4'b0000));
        base = yellow_light_count;
        wait_until(EV_GREEN_ON, "S green");
        void'(check_lamps(4'b1011, 4'b0000, 4'b0100));
        if (yellow_light_count !== base + 8'd1) begin
            report_mismatch("yellow_light_count", base + 8'd1, yellow_light_count);
        end
        rnd = lcg_next(rnd);
        repeat (rnd[23:16] % 6) @(posedge clk);
        set_switches(5'b11011);             // N and W join
        wait_sync_latency();
        void'(check_lamps(4'b1110, 4'b0000, 4'b0001));
        set_switches(5'b11001);             // N off
        wait_until(EV_YELLOW_ON, "N yellow");
        void'(check_lamps(4'b1110, 4'b0001, 4'b0000));
        base = yellow_light_count;
        wait_until(EV_YELLOW_OFF, "all-red hold");
        void'(check_lamps(4'b1111, 4'b0000, 4'b0000));
        if (yellow_light_count !== base + 8'd1) begin
            report_mismatch("yellow_light_count", base + 8'd1, yellow_light_count);
        end
        set_switches(5'b10001);             // S off inside the hold
        wait_until(EV_GREEN_ON, "W green");
        void'(check_lamps(4'b0111, 4'b0000, 4'b1000));
        if (active_direction !== 2'd3) begin
            report_mismatch("active_direction", 2'd3, active_direction);
        end
        repeat (4 * TB_TICKS) begin         // No late yellow for S
            @(negedge clk);
            void'(check_lamps(4'b0111, 4'b0000, 4'b1000));
        end
        if (yellow_light_count !== base + 8'd1) begin
            report_mismatch("yellow_light_count", base + 8'd1, yellow_light_count);
        end
        close_test("manual_sequential", errors - e0);

        // Back to auto, restart at North green
        e0 = errors;
        set_switches(5'b00000);
        wait_until(EV_SHOW_HIGH, "return to auto");
        void'(check_lamps(4'b1110, 4'b0000, 4'b0001));
        if (countdown_sec !== 8'(N_SECS)) begin
            report_mismatch("countdown_sec", N_SECS, countdown_sec);
        end
        @(posedge clk);
        cnt_en <= 1'b1;
        repeat (CYCLE_LEN) @(posedge clk);
        @(negedge clk);
        close_test("return_to_auto", errors - e0);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog, four auto cycles plus the manual waits, doubled
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a test did not finish", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- tl_phase_if.sv
`timescale 1ns/1ps

interface tl_phase_if;
    import tl_types_pkg::*;
    import tl_timing_pkg::*;

    // Auto side
    phase_t     phase;        // Current auto phase
    logic       pending;      // Manual requested, auto still finishing
    sec_t       remaining;    // Seconds left in phase, never zero

    // Manual side
    man_state_t man_state;
    lamp_t      man_yellow;   // One-hot, direction being cleared

    modport seq (
        output phase,
        output pending,
        output remaining
    );

    modport man (
        input  pending,
        output man_state,
        output man_yellow
    );

    modport drv (
        input phase,
        input pending,
        input remaining,
        input man_state,
        input man_yellow
    );

endinterface

//--- tl_timing_pkg.sv
package tl_timing_pkg;

    //==========================================================================
    // Time bases
    //==========================================================================
    localparam int TICK_W = 32;                             // Tick counter width
    localparam int unsigned DEFAULT_TICKS_PER_SEC = 100_000_000;  // 100 MHz board

    typedef logic [7:0]        sec_t;     // Whole seconds
    typedef logic [TICK_W-1:0] tick_t;    // Clock cycles within one second
    typedef logic [7:0]        count_t;   // Yellow onset count

    // A zero-second setting still runs for one second
    function automatic sec_t min_one_sec(sec_t s);
        return (s == '0) ? sec_t'(1) : s;
    endfunction

endpackage

//--- tl_types_pkg.sv
package tl_types_pkg;

    //==========================================================================
    // Directions and lamp vectors
    //==========================================================================
    typedef logic [1:0] dir_t;      // 0 N, 1 E, 2 S, 3 W
    typedef logic [3:0] lamp_t;     // One bit per direction, bit 0 is North
    typedef logic [4:0] sw_t;       // Bit 0 manual mode, bits 4..1 W S E N

    // Automatic cycle, three phases per direction in cycle order
    typedef enum logic [3:0] {
        N_GREEN,
        N_YELLOW,
        N_ALL_RED,
        E_GREEN,
        E_YELLOW,
        E_ALL_RED,
        S_GREEN,
        S_YELLOW,
        S_ALL_RED,
        W_GREEN,
        W_YELLOW,
        W_ALL_RED
    } phase_t;

    // Manual clearance FSM
    typedef enum logic [1:0] {
        IDLE,
        YELLOW,
        RED
    } man_state_t;

    // Lowest set bit as a one-hot vector, zero if none set
    function automatic lamp_t first_set(lamp_t v);
        return v & (~v + lamp_t'(1));
    endfunction

endpackage

//--- traffic_light_top.sv
`timescale 1ns/1ps

module traffic_light_top #(
    parameter int unsigned TICKS_PER_SEC = tl_timing_pkg::DEFAULT_TICKS_PER_SEC
) (
    input  logic                   clk,
    input  logic                   rst,
    input  tl_types_pkg::sw_t      switches,
    input  tl_timing_pkg::sec_t    n_duration,
    input  tl_timing_pkg::sec_t    e_duration,
    input  tl_timing_pkg::sec_t    s_duration,
    input  tl_timing_pkg::sec_t    w_duration,
    input  tl_timing_pkg::sec_t    yellow_duration,
    input  tl_timing_pkg::sec_t    red_holding,
    output tl_types_pkg::lamp_t    red_lamps,
    output tl_types_pkg::lamp_t    yellow_lamps,
    output tl_types_pkg::lamp_t    green_lamps,
    output tl_types_pkg::dir_t     active_direction,
    output tl_timing_pkg::sec_t    countdown_sec,
    output logic                   show_countdown,
    output tl_timing_pkg::count_t  yellow_light_count
);
    import tl_types_pkg::*;

    logic  manual;
    logic  manual_rise;
    lamp_t dir_sw;
    lamp_t dir_off;

    tl_phase_if ph_if_i ();                     // Controller state to lamp driver

    //==========================================================================
    // Input side
    //==========================================================================
    switch_conditioner cond_i (
        .clk         (clk),
        .rst         (rst),
        .switches    (switches),
        .manual      (manual),
        .manual_rise (manual_rise),
        .dir_sw      (dir_sw),
        .dir_off     (dir_off)
    );

    //==========================================================================
    // Processing
    //==========================================================================
    auto_sequencer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) seq_i (
        .clk             (clk),
        .rst             (rst),
        .manual          (manual),
        .manual_rise     (manual_rise),
        .n_duration      (n_duration),
        .e_duration      (e_duration),
        .s_duration      (s_duration),
        .w_duration      (w_duration),
        .yellow_duration (yellow_duration),
        .red_holding     (red_holding),
        .ph              (ph_if_i.seq)
    );

    manual_controller #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) man_i (
        .clk             (clk),
        .rst             (rst),
        .manual          (manual),
        .dir_off         (dir_off),
        .yellow_duration (yellow_duration),
        .red_holding     (red_holding),
        .ph              (ph_if_i.man)
    );

    //==========================================================================
    // Output side
    //==========================================================================
    lamp_driver drv_i (
        .clk                (clk),
        .rst                (rst),
        .manual             (manual),
        .dir_sw             (dir_sw),
        .ph                 (ph_if_i.drv),
        .red_lamps          (red_lamps),
        .yellow_lamps       (yellow_lamps),
        .green_lamps        (green_lamps),
        .active_direction   (active_direction),
        .countdown_sec      (countdown_sec),
        .show_countdown     (show_countdown),
        .yellow_light_count (yellow_light_count)
    );

endmodule
